/* ray_testdata.hex */
// signed Q16.16 words in hex, one ray and plane per line
// nx ny nz  v0x v0y v0z  ox oy oz  dx dy dz  expected_t
00000000 00000000 00010000 00000000 00000000 000a0000 00000000 00000000 00000000 00000000 00000000 00010000 000a0000
00000000 00000000 00010000 00000000 00000000 fffb0000 00000000 00000000 00000000 00000000 00000000 00010000 fffb0000
00000000 00010000 00000000 00000000 00060000 00000000 00000000 00010000 00000000 00000000 00020000 00000000 00028000
00008000 00000000 00000000 00040000 00000000 00000000 00000000 00000000 00000000 00010000 00000000 00000000 00040000
00000000 00000000 00010000 00000000 00000000 00000000 00000000 00000000 00080000 00000000 00000000 fffe0000 00040000
00010000 00000000 00000000 00030000 00000000 00000000 00000000 00000000 00000000 ffff0000 00000000 00000000 fffd0000
00000000 00000000 00010000 00000000 00000000 00010000 00000000 00000000 00000000 00000000 00000000 00030000 00005555
00000000 00000000 00010000 00000000 00000000 ffff0000 00000000 00000000 00000000 00000000 00000000 00030000 ffffaaab
00000000 00000000 00010000 00000000 00000000 00050000 00000000 00000000 00000000 00010000 00000000 00000000 7fffffff
00000000 00000000 00010000 00000000 00000000 fffb0000 00000000 00000000 00000000 00000000 00010000 00000000 80000000
00000000 00000000 00010000 00000000 00000000 00000000 00000000 00000000 00000000 00010000 00010000 00000000 7fffffff
00000000 00000000 00010000 00000000 00000000 03e80000 00000000 00000000 00000000 00000000 00000000 00000001 7fffffff
00000000 00000000 00010000 00000000 00000000 fc180000 00000000 00000000 00000000 00000000 00000000 00000001 80000000
00010000 00010000 00010000 00010000 00020000 00030000 00000000 00000000 00000000 00010000 00010000 00010000 00020000
00010000 00020000 00000000 00040000 00010000 00070000 00010000 00010000 00090000 00010000 00008000 00000000 00018000
00008000 00000000 00000000 ffffffff 00000000 00000000 00000000 00000000 00000000 00000002 00000000 00000000 ffff0000
00000000 00008000 00008000 00000000 00030000 00010000 00000000 00010000 00010000 00000000 00010000 00000000 00020000
ffff0000 00000000 00000000 00020000 00000000 00000000 fffa0000 00000000 00000000 fffe0000 00000000 00000000 fffc0000
00000000 00000000 00010000 00000000 00000000 00020000 00000000 00000000 00000000 00000000 00000000 00070000 00004924
00010000 00000000 00000000 00030000 00000000 00000000 00000000 00000000 00000000 00040000 00000000 00000000 0000c000
00000000 00010000 00000000 00000000 00050000 00000000 00000000 00050000 00000000 00000000 00010000 00000000 00000000
00010000 00010000 00000000 4e200000 4e200000 00000000 00000000 00000000 00000000 00010000 00000000 00000000 9c400000
00000000 00000000 00010000 00000000 00000000 75300000 00000000 00000000 00000000 00000000 00000000 00010000 75300000
00000000 00000000 00010000 00000000 00000000 80000000 00000000 00000000 00000000 00000000 00000000 00010000 80000000
00000000 00000000 00020000 00000000 00000000 00014000 00000000 00000000 00004000 00000000 00000000 ffff8000 fffe0000

/* flist.f */
ray_pkg.sv
operand_if.sv
hit_dot_stage.sv
hit_pair_fifo.sv
hit_divider.sv
ray_plane_hit.sv
tb_ray_plane_hit.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_ray_plane_hit
FLIST      := flist.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_ray_plane_hit.sv */
`timescale 1ns/1ps

module tb_ray_plane_hit import ray_pkg::*; ();

    localparam int n_cases        = 25;
    localparam int words_per_case = 13;
    // cases from here on are written with the output side stalled
    localparam int stall_start    = 10;
    // cases from here on are written back to back with reads always on
    localparam int burst_start    = 20;
    localparam int hold_len       = 60;
    localparam int cycle_limit    = n_cases * 60 + 200;

    logic   clock;
    logic   rst_n;
    vec3_t  tri_normal;
    vec3_t  v0;
    vec3_t  origin;
    vec3_t  dir;
    logic   in_wr_en;
    logic   in_full;
    coord_t t_out;
    logic   out_empty;
    logic   out_rd_en;

    coord_t      vectors [n_cases * words_per_case];
    coord_t      expected_q [$];
    coord_t      exp_t;
    logic [31:0] lfsr_state;
    int          wr_idx;
    int          rd_count;
    int          hold_cnt;
    int          cycles;
    int          value_errs;
    int          other_errs;
    logic        saw_full;

    ray_plane_hit ray_plane_hit_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .tri_normal (tri_normal),
        .v0         (v0),
        .origin     (origin),
        .dir        (dir),
        .in_wr_en   (in_wr_en),
        .in_full    (in_full),
        .t_out      (t_out),
        .out_empty  (out_empty),
        .out_rd_en  (out_rd_en)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bit(output logic b);
        lfsr_state = lfsr_step(lfsr_state);
        b = lfsr_state[0];
    endtask

    task automatic drive_case(input int idx);
        int base;
        base = idx * words_per_case;
        for (int k = 0; k < 3; k++) begin
            tri_normal[k] = vectors[base + k];
            v0[k]         = vectors[base + 3 + k];
            origin[k]     = vectors[base + 6 + k];
            dir[k]        = vectors[base + 9 + k];
        end
    endtask

    task automatic print_summary();
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    endtask

    // reads land on the next rising edge, so look at them half a cycle early
    always @(negedge clock) begin
        if (rst_n) begin
            if (in_full) begin
                saw_full = 1'b1;
            end
            if (out_rd_en && !out_empty) begin
                assert (expected_q.size() != 0) else begin
                    $display("result read while no case was outstanding");
                    other_errs++;
                end
                if (expected_q.size() != 0) begin
                    exp_t = expected_q.pop_front();
                    assert (t_out === exp_t) else begin
                        $display("[FAIL] t_out = %h, expected %h, result %0d%s", t_out, exp_t,
                                 rd_count, (exp_t == t_max || exp_t == t_min) ? " (sat)" : "");
                        value_errs++;
                    end
                end
                rd_count++;
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d results missing",
                     cycles, n_cases - rd_count, n_cases);
            other_errs++;
            print_summary();
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        logic b;
        logic want;
        lfsr_state = 32'h62b4_3161;
        wr_idx     = 0;
        rd_count   = 0;
        hold_cnt   = 0;
        cycles     = 0;
        value_errs = 0;
        other_errs = 0;
        saw_full   = 1'b0;
        rst_n      = 1'b0;
        in_wr_en   = 1'b0;
        out_rd_en  = 1'b0;
        tri_normal = '0;
        v0         = '0;
        origin     = '0;
        dir        = '0;
        $readmemh("ray_testdata.hex", vectors);
        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;

        @(negedge clock);
        assert (out_empty === 1'b1) else begin
            $display("[FAIL] out_empty = %h after reset, expected 1", out_empty);
            value_errs++;
        end
        assert (in_full === 1'b0) else begin
            $display("[FAIL] in_full = %h after reset, expected 0", in_full);
            value_errs++;
        end

        while (rd_count < n_cases) begin
            @(posedge clock);
            #1;
            if (wr_idx >= burst_start) begin
                out_rd_en = 1'b1;
            end else if (wr_idx >= stall_start && hold_cnt < hold_len) begin
                out_rd_en = 1'b0;
                hold_cnt++;
            end else begin
                draw_bit(b);
                out_rd_en = b;
            end

            // in_full only moves on an edge, so this sample holds until the next one
            want = 1'b0;
            if (wr_idx < n_cases && !in_full) begin
                if (wr_idx >= stall_start) begin
                    want = 1'b1;
                end else begin
                    draw_bit(want);
                end
            end
            if (want) begin
                drive_case(wr_idx);
                expected_q.push_back(vectors[wr_idx * words_per_case + 12]);
                wr_idx++;
            end
            in_wr_en = want;
        end

        out_rd_en = 1'b0;
        @(negedge clock);
        assert (out_empty === 1'b1) else begin
            $display("[FAIL] out_empty = %h after the last result, expected 1", out_empty);
            value_errs++;
        end
        assert (saw_full) else begin
            $display("in_full never rose while the output side was stalled");
            other_errs++;
        end
        assert (expected_q.size() == 0) else begin
            $display("%0d written cases were never returned", expected_q.size());
            other_errs++;
        end

        print_summary();
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* ray_plane_hit.sv */
`timescale 1ns/1ps

module ray_plane_hit import ray_pkg::*; (
    input  logic   clock,
    input  logic   rst_n,
    input  vec3_t  tri_normal,
    input  vec3_t  v0,
    input  vec3_t  origin,
    input  vec3_t  dir,
    input  logic   in_wr_en,
    output logic   in_full,
    output coord_t t_out,
    output logic   out_empty,
    input  logic   out_rd_en
);

    // stage to FIFO
    operand_if push_bus ();

    // FIFO to divider
    operand_if pop_bus ();

    hit_dot_stage u_dot_stage (
        .clock      (clock),
        .rst_n      (rst_n),
        .tri_normal (tri_normal),
        .v0         (v0),
        .origin     (origin),
        .dir        (dir),
        .in_wr_en   (in_wr_en),
        .in_full    (in_full),
        .push       (push_bus.writer)
    );

    hit_pair_fifo #(
        .depth      (pair_depth)
    ) u_pair_fifo (
        .clock      (clock),
        .rst_n      (rst_n),
        .wr_side    (push_bus.fifo_push),
        .rd_side    (pop_bus.fifo_pop)
    );

    hit_divider u_divider (
        .clock      (clock),
        .rst_n      (rst_n),
        .pop        (pop_bus.reader),
        .t_out      (t_out),
        .out_empty  (out_empty),
        .out_rd_en  (out_rd_en)
    );

endmodule

/* hit_divider.sv */
`timescale 1ns/1ps

module hit_divider import ray_pkg::*; (
    input  logic   clock,
    input  logic   rst_n,
    operand_if.reader pop,
    output coord_t t_out,
    output logic   out_empty,
    input  logic   out_rd_en
);

    div_state_t state;

    logic [$clog2(div_bits)-1:0] cnt;
    logic [div_bits-1:0]         acc;
    logic [div_bits-1:0]         acc_next;
    logic [div_bits-1:0]         q_src;
    logic [31:0]                 rem;
    logic [31:0]                 rem_next;
    logic [31:0]                 dmag;
    logic [31:0]                 num_mag;
    logic [31:0]                 den_mag;
    logic [32:0]                 trial;
    logic                        neg;
    logic                        num_neg;
    logic                        den_zero;
    logic                        last_step;
    logic                        done;
    logic                        res_free;
    logic                        res_valid;
    wide_t                       q_wide;
    coord_t                      res_next;
    coord_t                      res;

    assign pop.rd_en = (state == idle) && !pop.empty;

    always_comb begin
        num_mag = pop.num[31] ? -pop.num : pop.num;
        den_mag = pop.den[31] ? -pop.den : pop.den;
    end

    // one restoring step per run cycle
    always_comb begin
        trial = {rem, acc[div_bits-1]};
        if (trial >= {1'b0, dmag}) begin
            rem_next = 32'(trial - {1'b0, dmag});
            acc_next = {acc[div_bits-2:0], 1'b1};
        end else begin
            rem_next = trial[31:0];
            acc_next = {acc[div_bits-2:0], 1'b0};
        end
    end

    assign last_step = (state == run) && (cnt == ($clog2(div_bits))'(div_bits - 1));
    assign done      = last_step || (state == hold);
    assign res_free  = !res_valid || out_rd_en;

    // on the last step the quotient is still in flight
    assign q_src = (state == run) ? acc_next : acc;

    always_comb begin
        q_wide = wide_t'(q_src);
        if (neg) begin
            q_wide = -q_wide;
        end
        if (den_zero) begin
            res_next = num_neg ? t_min : t_max;
        end else if (q_wide > wide_t'(t_max)) begin
            res_next = t_max;
        end else if (q_wide < wide_t'(t_min)) begin
            res_next = t_min;
        end else begin
            res_next = coord_t'(q_wide);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state     <= idle;
            cnt       <= '0;
            res_valid <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (pop.rd_en) begin
                        state <= run;
                        cnt   <= '0;
                    end
                end
                run: begin
                    cnt <= cnt + 1'b1;
                    if (last_step) begin
                        state <= res_free ? idle : hold;
                    end
                end
                hold: begin
                    if (res_free) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase

            if (done && res_free) begin
                res_valid <= 1'b1;
            end else if (out_rd_en) begin
                res_valid <= 1'b0;
            end
        end
    end

    // operand capture and datapath
    always_ff @(posedge clock) begin
        if (pop.rd_en) begin
            acc      <= {num_mag, {q_bits{1'b0}}};
            rem      <= '0;
            dmag     <= den_mag;
            neg      <= pop.num[31] ^ pop.den[31];
            num_neg  <= pop.num[31];
            den_zero <= (pop.den == '0);
        end else if (state == run) begin
            acc <= acc_next;
            rem <= rem_next;
        end

        if (done && res_free) begin
            res <= res_next;
        end
    end

    assign t_out     = res;
    assign out_empty = !res_valid;

    // popped pair must start a division on the next cycle
    a_pop_from_idle: assert property (
        @(posedge clock) disable iff (!rst_n)
        pop.rd_en |-> (state == idle && !pop.empty) ##1 (state == run)
    ) else $error("pair popped outside idle or division not started");

endmodule

/* hit_pair_fifo.sv */
`timescale 1ns/1ps

module hit_pair_fifo import ray_pkg::*; #(
    parameter int depth = pair_depth
) (
    input logic clock,
    input logic rst_n,
    operand_if.fifo_push wr_side,
    operand_if.fifo_pop  rd_side
);

    coord_t num_mem [depth];
    coord_t den_mem [depth];

    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic [$clog2(depth):0]   count;
    logic                     do_wr;
    logic                     do_rd;

    assign do_rd = rd_side.rd_en && !rd_side.empty;
    // a write into a full buffer is fine when the head leaves on the same edge
    assign do_wr = wr_side.wr_en && (!wr_side.full || do_rd);

    assign wr_side.full  = (count == ($clog2(depth) + 1)'(depth));
    assign rd_side.empty = (count == '0);

    // show-ahead head entry
    assign rd_side.num = num_mem[rd_ptr];
    assign rd_side.den = den_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_wr) begin
            num_mem[wr_ptr] <= wr_side.num;
            den_mem[wr_ptr] <= wr_side.den;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_in_range: assert property (
        @(posedge clock) disable iff (!rst_n)
        count <= ($clog2(depth) + 1)'(depth)
    ) else $error("pair FIFO occupancy above depth");

endmodule

/* hit_dot_stage.sv */
`timescale 1ns/1ps

module hit_dot_stage import ray_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    input  vec3_t tri_normal,
    input  vec3_t v0,
    input  vec3_t origin,
    input  vec3_t dir,
    input  logic  in_wr_en,
    output logic  in_full,
    operand_if.writer push
);

    logic   stall;
    logic   accept;
    logic   s1_valid;
    logic   s2_valid;
    vec3_t  prod_v0;
    vec3_t  prod_org;
    vec3_t  prod_dir;
    coord_t sum_v0;
    coord_t sum_org;
    coord_t sum_dir;
    coord_t num_q;
    coord_t den_q;

    // Q16.16 multiply, truncated back to 32 bits
    function automatic coord_t fx_mul(input coord_t a, input coord_t b);
        wide_t full_prod;
        full_prod = wide_t'(a) * wide_t'(b);
        return coord_t'(full_prod >>> q_bits);
    endfunction

    // whole pipeline freezes while the output pair waits on a full FIFO
    assign stall   = s2_valid && push.full;
    assign in_full = stall;
    assign accept  = in_wr_en && !stall;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= in_wr_en;
            s2_valid <= s1_valid;
        end
    end

    // stage 1, nine products
    always_ff @(posedge clock) begin
        if (accept) begin
            for (int i = 0; i < 3; i++) begin
                prod_v0[i]  <= fx_mul(tri_normal[i], v0[i]);
                prod_org[i] <= fx_mul(tri_normal[i], origin[i]);
                prod_dir[i] <= fx_mul(tri_normal[i], dir[i]);
            end
        end
    end

    // wrapping sums of each group
    always_comb begin
        sum_v0  = prod_v0[0] + prod_v0[1] + prod_v0[2];
        sum_org = prod_org[0] + prod_org[1] + prod_org[2];
        sum_dir = prod_dir[0] + prod_dir[1] + prod_dir[2];
    end

    // stage 2, numerator and denominator
    always_ff @(posedge clock) begin
        if (!stall && s1_valid) begin
            num_q <= sum_v0 - sum_org;
            den_q <= sum_dir;
        end
    end

    assign push.num   = num_q;
    assign push.den   = den_q;
    assign push.wr_en = s2_valid && !push.full;

    a_no_write_when_full: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(in_wr_en && in_full)
    ) else $error("input write while in_full is high");

    // full comes from the pair FIFO
    a_no_push_when_full: assert property (
        @(posedge clock) disable iff (!rst_n)
        push.wr_en |-> !push.full
    ) else $error("pair pushed into a full FIFO");

endmodule

/* operand_if.sv */
`timescale 1ns/1ps

interface operand_if import ray_pkg::*; ();

    coord_t num;
    coord_t den;
    logic   wr_en;
    logic   full;
    logic   rd_en;
    logic   empty;

    // producer into the pair FIFO
    modport writer (output num, den, wr_en, input full);

    // FIFO write side
    modport fifo_push (input num, den, wr_en, output full);

    // FIFO read side, show-ahead
    modport fifo_pop (output num, den, empty, input rd_en);

    // consumer out of the pair FIFO
    modport reader (input num, den, empty, output rd_en);

endinterface

/* ray_pkg.sv */
package ray_pkg;

    // fraction bits of the Q16.16 format
    localparam int q_bits = 16;

    // signed Q16.16 coordinate or truncated product
    typedef logic signed [31:0] coord_t;

    // element 0 is x, 1 is y, 2 is z
    typedef coord_t [2:0] vec3_t;

    // full product before rescaling
    typedef logic signed [63:0] wide_t;

    // saturation limits of the result
    localparam coord_t t_max = 32'sh7fff_ffff;
    localparam coord_t t_min = 32'sh8000_0000;

    // default depth of the pair FIFO
    localparam int pair_depth = 4;

    // dividend bits walked by the divider, |num| << q_bits
    localparam int div_bits = $bits(coord_t) + q_bits;

    typedef enum logic [1:0] {
        idle,
        run,
        hold
    } div_state_t;

endpackage
